/* Makefile */
VERILATOR ?= verilator
TOP       ?= int_core_tb
FILELIST  ?= int_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* hdl/core_pkg.sv */
// Datapath widths, register id and word types, alu operation enum
package core_pkg;

  localparam int XLEN = 64;

  // Word forms work on this many low bits, then sign-extend
  localparam int WORD_BITS = 32;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [4:0]           reg_id_t;

  // Shift amounts, 6 bits for full width and 5 for word forms
  typedef logic [5:0] shamt_t;
  typedef logic [4:0] shamt_w_t;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    // LUI result is the immediate itself
    ALU_PASS_B = 4'd10
  } alu_op_e;

endpackage

/* hdl/int_core.sv */
// Integer core top level: decode, execute and result stages
module int_core #(
  parameter int REG_COUNT = 32
) (
  input  logic                clk,
  input  logic                rstn,
  input  logic                inst_valid,
  input  rv_isa_pkg::inst_t   inst,
  output logic                retire_valid,
  output logic                retire_we,
  output core_pkg::reg_id_t   retire_rd,
  output core_pkg::xlen_t     retire_data
);

  logic              dec_valid;
  logic              dec_we;
  core_pkg::alu_op_e dec_alu_op;
  logic              dec_word;
  logic              dec_use_imm;
  core_pkg::xlen_t   dec_imm;
  core_pkg::reg_id_t dec_rs1;
  core_pkg::reg_id_t dec_rs2;
  core_pkg::reg_id_t dec_rd;

  core_pkg::reg_id_t rf_rs1;
  core_pkg::reg_id_t rf_rs2;
  core_pkg::xlen_t   rf_rs1_data;
  core_pkg::xlen_t   rf_rs2_data;

  logic              ex_valid;
  logic              ex_we;
  core_pkg::reg_id_t ex_rd;
  core_pkg::xlen_t   ex_data;

  int_decode #(
    .REG_COUNT (REG_COUNT)
  ) u_decode (
    .clk         (clk),
    .rstn        (rstn),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .dec_valid   (dec_valid),
    .dec_we      (dec_we),
    .dec_alu_op  (dec_alu_op),
    .dec_word    (dec_word),
    .dec_use_imm (dec_use_imm),
    .dec_imm     (dec_imm),
    .dec_rs1     (dec_rs1),
    .dec_rs2     (dec_rs2),
    .dec_rd      (dec_rd)
  );

  int_execute u_execute (
    .clk         (clk),
    .rstn        (rstn),
    .dec_valid   (dec_valid),
    .dec_we      (dec_we),
    .dec_alu_op  (dec_alu_op),
    .dec_word    (dec_word),
    .dec_use_imm (dec_use_imm),
    .dec_imm     (dec_imm),
    .dec_rs1     (dec_rs1),
    .dec_rs2     (dec_rs2),
    .dec_rd      (dec_rd),
    .rf_rs1      (rf_rs1),
    .rf_rs2      (rf_rs2),
    .rf_rs1_data (rf_rs1_data),
    .rf_rs2_data (rf_rs2_data),
    .ex_valid    (ex_valid),
    .ex_we       (ex_we),
    .ex_rd       (ex_rd),
    .ex_data     (ex_data)
  );

  int_result #(
    .REG_COUNT (REG_COUNT)
  ) u_result (
    .clk          (clk),
    .rstn         (rstn),
    .rf_rs1       (rf_rs1),
    .rf_rs2       (rf_rs2),
    .rf_rs1_data  (rf_rs1_data),
    .rf_rs2_data  (rf_rs2_data),
    .ex_valid     (ex_valid),
    .ex_we        (ex_we),
    .ex_rd        (ex_rd),
    .ex_data      (ex_data),
    .retire_valid (retire_valid),
    .retire_we    (retire_we),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

endmodule

/* hdl/int_decode.sv */
// Decode stage: field split, alu op mapping, immediates and the decode register
module int_decode #(
  parameter int REG_COUNT = 32
) (
  input  logic                clk,
  input  logic                rstn,
  input  logic                inst_valid,
  input  rv_isa_pkg::inst_t   inst,
  output logic                dec_valid,
  output logic                dec_we,
  output core_pkg::alu_op_e   dec_alu_op,
  output logic                dec_word,
  output logic                dec_use_imm,
  output core_pkg::xlen_t     dec_imm,
  output core_pkg::reg_id_t   dec_rs1,
  output core_pkg::reg_id_t   dec_rs2,
  output core_pkg::reg_id_t   dec_rd
);

  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::funct7_t funct7;
  core_pkg::reg_id_t   rs1;
  core_pkg::reg_id_t   rs2;
  core_pkg::reg_id_t   rd;
  core_pkg::xlen_t     imm_i;
  core_pkg::xlen_t     imm_u;
  core_pkg::xlen_t     imm_sh;
  core_pkg::xlen_t     imm_sh_w;
  core_pkg::xlen_t     imm;
  core_pkg::alu_op_e   alu_op;
  logic                known;
  logic                word;
  logic                use_imm;
  logic                uses_rs1;
  logic                uses_rs2;
  logic                ids_ok;
  logic                is_base;
  logic                is_alt;

  // Shared mapping; alt only matters for add/sub and srl/sra
  function automatic core_pkg::alu_op_e arith_op(rv_isa_pkg::funct3_t f3, logic alt);
    core_pkg::alu_op_e op;
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: op = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     op = core_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     op = core_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    op = core_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     op = core_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL_SRA: op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      op = core_pkg::ALU_OR;
      default:                op = core_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  assign is_base = (funct7 == rv_isa_pkg::FUNCT7_BASE);
  assign is_alt  = (funct7 == rv_isa_pkg::FUNCT7_ALT);

  assign imm_i    = {{(core_pkg::XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_u    = {{(core_pkg::XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_sh   = {{(core_pkg::XLEN-6){1'b0}}, inst[25:20]};
  assign imm_sh_w = {{(core_pkg::XLEN-5){1'b0}}, inst[24:20]};

  always_comb begin
    known    = 1'b0;
    word     = 1'b0;
    use_imm  = 1'b0;
    uses_rs1 = 1'b1;
    uses_rs2 = 1'b0;
    imm      = imm_i;
    alu_op   = arith_op(funct3, inst[30] && (funct3 == rv_isa_pkg::F3_SRL_SRA));
    case (opcode)
      rv_isa_pkg::OPC_OP: begin
        uses_rs2 = 1'b1;
        alu_op   = arith_op(funct3, inst[30]);
        known    = is_base || (is_alt && (funct3 == rv_isa_pkg::F3_ADD_SUB ||
                                          funct3 == rv_isa_pkg::F3_SRL_SRA));
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        use_imm = 1'b1;
        known   = 1'b1;
        // shamt[5] sits in funct7[0] on RV64
        if (funct3 == rv_isa_pkg::F3_SLL) begin
          imm   = imm_sh;
          known = (funct7[6:1] == rv_isa_pkg::FUNCT7_BASE[6:1]);
        end else if (funct3 == rv_isa_pkg::F3_SRL_SRA) begin
          imm   = imm_sh;
          known = (funct7[6:1] == rv_isa_pkg::FUNCT7_BASE[6:1]) ||
                  (funct7[6:1] == rv_isa_pkg::FUNCT7_ALT[6:1]);
        end
      end
      rv_isa_pkg::OPC_OP_32: begin
        word     = 1'b1;
        uses_rs2 = 1'b1;
        alu_op   = arith_op(funct3, inst[30]);
        known    = (is_base && (funct3 == rv_isa_pkg::F3_ADD_SUB ||
                                funct3 == rv_isa_pkg::F3_SLL ||
                                funct3 == rv_isa_pkg::F3_SRL_SRA)) ||
                   (is_alt && (funct3 == rv_isa_pkg::F3_ADD_SUB ||
                               funct3 == rv_isa_pkg::F3_SRL_SRA));
      end
      rv_isa_pkg::OPC_OP_IMM_32: begin
        word    = 1'b1;
        use_imm = 1'b1;
        if (funct3 == rv_isa_pkg::F3_ADD_SUB) begin
          known = 1'b1;
        end else if (funct3 == rv_isa_pkg::F3_SLL) begin
          imm   = imm_sh_w;
          known = is_base;
        end else if (funct3 == rv_isa_pkg::F3_SRL_SRA) begin
          imm   = imm_sh_w;
          known = is_base || is_alt;
        end
      end
      rv_isa_pkg::OPC_LUI: begin
        uses_rs1 = 1'b0;
        use_imm  = 1'b1;
        imm      = imm_u;
        alu_op   = core_pkg::ALU_PASS_B;
        known    = 1'b1;
      end
      default: known = 1'b0;
    endcase
  end

  // Only matters for the E variant
  assign ids_ok = (rd < REG_COUNT) &&
                  (!uses_rs1 || rs1 < REG_COUNT) &&
                  (!uses_rs2 || rs2 < REG_COUNT);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      dec_valid <= 1'b0;
      dec_we    <= 1'b0;
    end else begin
      dec_valid <= inst_valid;
      dec_we    <= inst_valid && known && ids_ok && (rd != '0);
    end
  end

  always_ff @(posedge clk) begin
    dec_alu_op  <= alu_op;
    dec_word    <= word;
    dec_use_imm <= use_imm;
    dec_imm     <= imm;
    dec_rs1     <= rs1;
    dec_rs2     <= rs2;
    dec_rd      <= rd;
  end

  a_inst_valid_known: assert property (@(posedge clk) disable iff (!rstn)
    !$isunknown(inst_valid));

endmodule

/* hdl/int_execute.sv */
// Execute stage: operand forwarding and select, alu, execute register
module int_execute (
  input  logic                clk,
  input  logic                rstn,
  input  logic                dec_valid,
  input  logic                dec_we,
  input  core_pkg::alu_op_e   dec_alu_op,
  input  logic                dec_word,
  input  logic                dec_use_imm,
  input  core_pkg::xlen_t     dec_imm,
  input  core_pkg::reg_id_t   dec_rs1,
  input  core_pkg::reg_id_t   dec_rs2,
  input  core_pkg::reg_id_t   dec_rd,
  output core_pkg::reg_id_t   rf_rs1,
  output core_pkg::reg_id_t   rf_rs2,
  input  core_pkg::xlen_t     rf_rs1_data,
  input  core_pkg::xlen_t     rf_rs2_data,
  output logic                ex_valid,
  output logic                ex_we,
  output core_pkg::reg_id_t   ex_rd,
  output core_pkg::xlen_t     ex_data
);

  core_pkg::xlen_t    op_a;
  core_pkg::xlen_t    rs2_val;
  core_pkg::xlen_t    op_b;
  core_pkg::xlen_t    full_res;
  core_pkg::xlen_t    alu_res;
  core_pkg::word_t    a_w;
  core_pkg::word_t    word_res;
  core_pkg::shamt_t   shamt;
  core_pkg::shamt_w_t shamt_w;
  logic               fwd_ok;

  assign rf_rs1 = dec_rs1;
  assign rf_rs2 = dec_rs2;

  // Bypass from the instruction one ahead; older ones are already in the file
  assign fwd_ok  = ex_valid && ex_we;
  assign op_a    = (fwd_ok && ex_rd == dec_rs1) ? ex_data : rf_rs1_data;
  assign rs2_val = (fwd_ok && ex_rd == dec_rs2) ? ex_data : rf_rs2_data;
  assign op_b    = dec_use_imm ? dec_imm : rs2_val;

  assign a_w     = op_a[core_pkg::WORD_BITS-1:0];
  assign shamt   = op_b[5:0];
  assign shamt_w = op_b[4:0];

  always_comb begin
    case (dec_alu_op)
      core_pkg::ALU_ADD:    full_res = op_a + op_b;
      core_pkg::ALU_SUB:    full_res = op_a - op_b;
      core_pkg::ALU_SLL:    full_res = op_a << shamt;
      core_pkg::ALU_SLT:    full_res = {{(core_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      core_pkg::ALU_SLTU:   full_res = {{(core_pkg::XLEN-1){1'b0}}, op_a < op_b};
      core_pkg::ALU_XOR:    full_res = op_a ^ op_b;
      core_pkg::ALU_SRL:    full_res = op_a >> shamt;
      core_pkg::ALU_SRA:    full_res = core_pkg::xlen_t'($signed(op_a) >>> shamt);
      core_pkg::ALU_OR:     full_res = op_a | op_b;
      core_pkg::ALU_AND:    full_res = op_a & op_b;
      core_pkg::ALU_PASS_B: full_res = op_b;
      default:              full_res = '0;
    endcase
  end

  // Word add/sub match the low half of the full result
  always_comb begin
    case (dec_alu_op)
      core_pkg::ALU_SLL: word_res = a_w << shamt_w;
      core_pkg::ALU_SRL: word_res = a_w >> shamt_w;
      core_pkg::ALU_SRA: word_res = core_pkg::word_t'($signed(a_w) >>> shamt_w);
      default:           word_res = full_res[core_pkg::WORD_BITS-1:0];
    endcase
  end

  assign alu_res = dec_word ?
                   {{(core_pkg::XLEN-core_pkg::WORD_BITS){word_res[core_pkg::WORD_BITS-1]}},
                    word_res} :
                   full_res;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ex_valid <= 1'b0;
      ex_we    <= 1'b0;
    end else begin
      ex_valid <= dec_valid;
      ex_we    <= dec_we;
    end
  end

  always_ff @(posedge clk) begin
    ex_rd   <= dec_rd;
    ex_data <= alu_res;
  end

  // Relies on decode never raising dec_we without dec_valid
  a_we_needs_valid: assert property (@(posedge clk) disable iff (!rstn)
    ex_we |-> ex_valid);

endmodule

/* hdl/int_result.sv */
// Register file with two read ports, write-back and retire registers
module int_result #(
  parameter int REG_COUNT = 32
) (
  input  logic                clk,
  input  logic                rstn,
  input  core_pkg::reg_id_t   rf_rs1,
  input  core_pkg::reg_id_t   rf_rs2,
  output core_pkg::xlen_t     rf_rs1_data,
  output core_pkg::xlen_t     rf_rs2_data,
  input  logic                ex_valid,
  input  logic                ex_we,
  input  core_pkg::reg_id_t   ex_rd,
  input  core_pkg::xlen_t     ex_data,
  output logic                retire_valid,
  output logic                retire_we,
  output core_pkg::reg_id_t   retire_rd,
  output core_pkg::xlen_t     retire_data
);

  localparam int IDX_W = $clog2(REG_COUNT);

  core_pkg::xlen_t regs [REG_COUNT];
  logic            wr_en;

  assign wr_en = ex_valid && ex_we;

  // Entry zero is never written, decode clears we for rd zero
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[ex_rd[IDX_W-1:0]] <= ex_data;
    end
  end

  // Out of range ids belong to unsupported encodings and read as zero
  assign rf_rs1_data = (rf_rs1 != '0 && rf_rs1 < REG_COUNT) ? regs[rf_rs1[IDX_W-1:0]] : '0;
  assign rf_rs2_data = (rf_rs2 != '0 && rf_rs2 < REG_COUNT) ? regs[rf_rs2[IDX_W-1:0]] : '0;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      retire_valid <= 1'b0;
      retire_we    <= 1'b0;
    end else begin
      retire_valid <= ex_valid;
      retire_we    <= wr_en;
    end
  end

  always_ff @(posedge clk) begin
    retire_rd   <= ex_rd;
    retire_data <= ex_data;
  end

  a_write_addr_ok: assert property (@(posedge clk) disable iff (!rstn)
    wr_en |-> (ex_rd != '0 && ex_rd < REG_COUNT));

endmodule

/* hdl/rv_isa_pkg.sv */
// RISC-V instruction field types, opcode, funct3 and funct7 constants
package rv_isa_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // Major opcodes of the integer arithmetic group
  localparam opcode_t OPC_OP        = 7'b0110011;
  localparam opcode_t OPC_OP_IMM    = 7'b0010011;
  localparam opcode_t OPC_OP_32     = 7'b0111011;
  localparam opcode_t OPC_OP_IMM_32 = 7'b0011011;
  localparam opcode_t OPC_LUI       = 7'b0110111;

  // funct3 of the arithmetic functions
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // Base and alternate funct7; the alternate one picks sub and sra
  localparam funct7_t FUNCT7_BASE = 7'b0000000;
  localparam funct7_t FUNCT7_ALT  = 7'b0100000;

endpackage

/* int_core.f */
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/int_decode.sv
hdl/int_execute.sv
hdl/int_result.sv
hdl/int_core.sv
testbench/int_core_tb.sv

/* testbench/int_core_tb.sv */
// Testbench for int_core: clock, reset, stimulus, reference model, compare process, checks
module int_core_tb;

  localparam int RESET_CYCLES    = 8;
  localparam int PROLOGUE_CYCLES = 17;
  localparam int RAND_COUNT      = 400;
  localparam int LATENCY         = 3;
  localparam int CYCLE_LIMIT     = RESET_CYCLES + PROLOGUE_CYCLES + RAND_COUNT + LATENCY + 20;

  typedef struct packed {
    logic              valid;
    logic              we;
    core_pkg::reg_id_t rd;
    core_pkg::xlen_t   data;
  } retire_t;

  logic              clk = 1'b0;
  logic              rstn;
  logic              inst_valid;
  rv_isa_pkg::inst_t inst;
  logic              retire_valid;
  logic              retire_we;
  core_pkg::reg_id_t retire_rd;
  core_pkg::xlen_t   retire_data;

  core_pkg::xlen_t   model_regs [32];
  retire_t           exp_q [$];
  retire_t           entry;
  logic              exp_we;
  core_pkg::xlen_t   exp_data;
  int                issued = 0;
  int                checked = 0;
  int                cycles = 0;

  int_core #(
    .REG_COUNT (32)
  ) u_int_core (
    .clk          (clk),
    .rstn         (rstn),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .retire_valid (retire_valid),
    .retire_we    (retire_we),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  always #5 clk = ~clk;

  task automatic check_xlen(input string name, input core_pkg::xlen_t got,
                            input core_pkg::xlen_t expected);
    if (got !== expected) begin
      $display("FAIL time %0t %s got %h expected %h", $time, name, got, expected);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  task automatic check_reg_id(input string name, input core_pkg::reg_id_t got,
                              input core_pkg::reg_id_t expected);
    if (got !== expected) begin
      $display("FAIL time %0t %s got %0d expected %0d", $time, name, got, expected);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("FAIL time %0t %s got %b expected %b", $time, name, got, expected);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  // 64-bit arithmetic by funct3, alt selects sub and sra
  function automatic core_pkg::xlen_t full_op(input rv_isa_pkg::funct3_t f3, input logic alt,
                                              input core_pkg::xlen_t a, input core_pkg::xlen_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[5:0];
      3'd2:    return core_pkg::xlen_t'($signed(a) < $signed(b));
      3'd3:    return core_pkg::xlen_t'(a < b);
      3'd4:    return a ^ b;
      3'd5:    return alt ? core_pkg::xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic core_pkg::word_t word_op(input rv_isa_pkg::funct3_t f3, input logic alt,
                                              input core_pkg::word_t a, input core_pkg::word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd5:    return alt ? core_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      default: return '0;
    endcase
  endfunction

  // Reference model, updates its own register copy
  function automatic void predict(input rv_isa_pkg::inst_t i, output logic we,
                                  output core_pkg::xlen_t data);
    rv_isa_pkg::funct3_t f3;
    rv_isa_pkg::funct7_t f7;
    core_pkg::xlen_t     a;
    core_pkg::xlen_t     b;
    core_pkg::xlen_t     imm;
    logic                ok;
    logic                alt;
    f3   = i[14:12];
    f7   = i[31:25];
    a    = model_regs[i[19:15]];
    b    = model_regs[i[24:20]];
    imm  = {{52{i[31]}}, i[31:20]};
    alt  = (f7 == rv_isa_pkg::FUNCT7_ALT);
    ok   = 1'b0;
    data = '0;
    case (i[6:0])
      rv_isa_pkg::OPC_OP: begin
        ok   = (f7 == rv_isa_pkg::FUNCT7_BASE) || (alt && (f3 == 3'd0 || f3 == 3'd5));
        data = full_op(f3, alt, a, b);
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        ok = 1'b1;
        if (f3 == 3'd1) ok = (i[31:26] == 6'b000000);
        if (f3 == 3'd5) ok = (i[31:26] == 6'b000000) || (i[31:26] == 6'b010000);
        data = full_op(f3, (f3 == 3'd5) && i[30], a, imm);
      end
      rv_isa_pkg::OPC_OP_32: begin
        ok = ((f7 == rv_isa_pkg::FUNCT7_BASE) && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5)) ||
             (alt && (f3 == 3'd0 || f3 == 3'd5));
        data = {{32{1'b0}}, word_op(f3, alt, a[31:0], b[31:0])};
        data = {{32{data[31]}}, data[31:0]};
      end
      rv_isa_pkg::OPC_OP_IMM_32: begin
        ok = (f3 == 3'd0) || (f3 == 3'd1 && f7 == rv_isa_pkg::FUNCT7_BASE) ||
             (f3 == 3'd5 && (f7 == rv_isa_pkg::FUNCT7_BASE || alt));
        data = {{32{1'b0}}, word_op(f3, alt && (f3 == 3'd5), a[31:0], imm[31:0])};
        data = {{32{data[31]}}, data[31:0]};
      end
      rv_isa_pkg::OPC_LUI: begin
        ok   = 1'b1;
        data = {{32{i[31]}}, i[31:12], 12'h000};
      end
      default: ok = 1'b0;
    endcase
    we = ok && (i[11:7] != 5'd0);
    if (we) model_regs[i[11:7]] = data;
  endfunction

  function automatic rv_isa_pkg::inst_t make_r(input rv_isa_pkg::funct7_t f7,
      input core_pkg::reg_id_t rs2, input core_pkg::reg_id_t rs1,
      input rv_isa_pkg::funct3_t f3, input core_pkg::reg_id_t rd, input rv_isa_pkg::opcode_t opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic rv_isa_pkg::inst_t make_i(input logic [11:0] imm,
      input core_pkg::reg_id_t rs1, input rv_isa_pkg::funct3_t f3,
      input core_pkg::reg_id_t rd, input rv_isa_pkg::opcode_t opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_isa_pkg::inst_t make_u(input logic [19:0] imm, input core_pkg::reg_id_t rd);
    return {imm, rd, rv_isa_pkg::OPC_LUI};
  endfunction

  // Mostly low registers so that random code forms dependency chains
  function automatic core_pkg::reg_id_t pick_reg();
    return ($urandom % 4 == 0) ? 5'($urandom) : 5'($urandom % 8);
  endfunction

  function automatic rv_isa_pkg::inst_t random_inst();
    int unsigned         kind;
    rv_isa_pkg::funct3_t f3;
    logic                alt;
    logic [11:0]         imm;
    kind = $urandom % 14;
    f3   = 3'($urandom);
    alt  = 1'($urandom);
    imm  = 12'($urandom);
    if (kind >= 8 && kind < 12) begin
      f3 = ($urandom % 3 == 0) ? 3'd0 : (($urandom % 2 == 0) ? 3'd1 : 3'd5);
    end
    if (kind < 5) begin
      return make_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? rv_isa_pkg::FUNCT7_ALT :
                    rv_isa_pkg::FUNCT7_BASE, pick_reg(), pick_reg(), f3, pick_reg(),
                    rv_isa_pkg::OPC_OP);
    end else if (kind < 8) begin
      if (f3 == 3'd1) imm[11:6] = 6'b000000;
      if (f3 == 3'd5) imm[11:6] = alt ? 6'b010000 : 6'b000000;
      return make_i(imm, pick_reg(), f3, pick_reg(), rv_isa_pkg::OPC_OP_IMM);
    end else if (kind < 10) begin
      return make_r((alt && f3 != 3'd1) ? rv_isa_pkg::FUNCT7_ALT : rv_isa_pkg::FUNCT7_BASE,
                    pick_reg(), pick_reg(), f3, pick_reg(), rv_isa_pkg::OPC_OP_32);
    end else if (kind < 12) begin
      if (f3 != 3'd0) imm[11:5] = (alt && f3 == 3'd5) ? rv_isa_pkg::FUNCT7_ALT :
                                  rv_isa_pkg::FUNCT7_BASE;
      return make_i(imm, pick_reg(), f3, pick_reg(), rv_isa_pkg::OPC_OP_IMM_32);
    end else if (kind == 12) begin
      return make_u(20'($urandom), pick_reg());
    end
    // Raw bits, mostly unsupported encodings
    return $urandom;
  endfunction

  task automatic issue(input rv_isa_pkg::inst_t i);
    @(negedge clk);
    inst_valid = 1'b1;
    inst       = i;
    issued++;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      inst_valid = 1'b0;
      inst       = $urandom;
    end
  endtask

  initial begin
    void'($urandom(32'ha46c));
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    rstn       = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rstn = 1'b1;
    // Dependent chain through forwarding and the register file
    issue(make_u(20'hfedcb, 5'd1));
    issue(make_i(12'h7ff, 5'd1, rv_isa_pkg::F3_ADD_SUB, 5'd1, rv_isa_pkg::OPC_OP_IMM));
    issue(make_r(rv_isa_pkg::FUNCT7_BASE, 5'd1, 5'd1, rv_isa_pkg::F3_ADD_SUB, 5'd2,
                 rv_isa_pkg::OPC_OP));
    issue(make_r(rv_isa_pkg::FUNCT7_ALT, 5'd1, 5'd2, rv_isa_pkg::F3_ADD_SUB, 5'd3,
                 rv_isa_pkg::OPC_OP));
    // Word forms with shift amount 31
    issue(make_i(12'd31, 5'd3, rv_isa_pkg::F3_SLL, 5'd4, rv_isa_pkg::OPC_OP_IMM_32));
    issue(make_i({rv_isa_pkg::FUNCT7_ALT, 5'd31}, 5'd2, rv_isa_pkg::F3_SRL_SRA, 5'd5,
                 rv_isa_pkg::OPC_OP_IMM_32));
    issue(make_r(rv_isa_pkg::FUNCT7_ALT, 5'd1, 5'd4, rv_isa_pkg::F3_ADD_SUB, 5'd6,
                 rv_isa_pkg::OPC_OP_32));
    issue(make_r(rv_isa_pkg::FUNCT7_BASE, 5'd2, 5'd6, rv_isa_pkg::F3_SRL_SRA, 5'd7,
                 rv_isa_pkg::OPC_OP_32));
    idle(2);
    // sltw does not exist, x5 must keep its value
    issue(make_r(rv_isa_pkg::FUNCT7_BASE, 5'd1, 5'd1, rv_isa_pkg::F3_SLT, 5'd5,
                 rv_isa_pkg::OPC_OP_32));
    issue(make_i(12'h123, 5'd1, rv_isa_pkg::F3_ADD_SUB, 5'd0, rv_isa_pkg::OPC_OP_IMM));
    issue(make_r(rv_isa_pkg::FUNCT7_BASE, 5'd0, 5'd5, rv_isa_pkg::F3_OR, 5'd8,
                 rv_isa_pkg::OPC_OP));
    idle(1);
    issue(make_r(rv_isa_pkg::FUNCT7_BASE, 5'd0, 5'd0, rv_isa_pkg::F3_ADD_SUB, 5'd9,
                 rv_isa_pkg::OPC_OP));
    issue(make_i(12'h800, 5'd8, rv_isa_pkg::F3_SLTU, 5'd10, rv_isa_pkg::OPC_OP_IMM));
    issue(make_i(12'h43f, 5'd1, rv_isa_pkg::F3_SRL_SRA, 5'd11, rv_isa_pkg::OPC_OP_IMM));
    for (int n = 0; n < RAND_COUNT; n++) begin
      if ($urandom % 6 == 0) begin
        idle(1);
      end else begin
        issue(random_inst());
      end
    end
    idle(1);
    wait (checked == issued);
    @(negedge clk);
    $display("Done: no errors");
    $finish;
  end

  // Inputs captured at the rising edge, outputs checked at the falling edge
  always begin
    @(posedge clk);
    if (rstn) begin
      exp_we   = 1'b0;
      exp_data = '0;
      if (inst_valid) predict(inst, exp_we, exp_data);
      exp_q.push_back('{valid: inst_valid, we: exp_we, rd: inst[11:7], data: exp_data});
    end
    @(negedge clk);
    if (exp_q.size() == LATENCY) begin
      entry = exp_q.pop_front();
      check_bit("retire_valid", retire_valid, entry.valid);
      if (entry.valid) begin
        check_bit("retire_we", retire_we, entry.we);
        check_reg_id("retire_rd", retire_rd, entry.rd);
        if (entry.we) check_xlen("retire_data", retire_data, entry.data);
        checked++;
      end else begin
        check_bit("retire_we", retire_we, 1'b0);
      end
    end else begin
      check_bit("retire_valid", retire_valid, 1'b0);
      check_bit("retire_we", retire_we, 1'b0);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: not every issued instruction retired within %0d cycles", CYCLE_LIMIT);
      $display("Done: errors found");
      $fatal(1);
    end
  end

endmodule
